// File: src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths
`define DATA_W 8
`define ADDR_W 16
`define PC_W 8
`define DEV_W 5

// destination device codes, as carried in the low five bits of the hi byte
`define DEV_NONE 5'd0
`define DEV_MARLO 5'd1
`define DEV_MARHI 5'd2
`define DEV_UART 5'd3
`define DEV_RAM 5'd4
`define DEV_PC 5'd5
`define DEV_HALT 5'd6

// general registers sit at 16..19, top device bit set
`define DEV_REG0 5'd16

// the uart occupies a single byte of bus space
`define UART_ADDR 16'hFF00

`endif

// File: src/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    // plain vectors with a meaning
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`PC_W-1:0] pc_t;
    typedef logic [`DEV_W-1:0] dev_t;
    typedef logic [1:0] reg_sel_t;

    // top three bits of the program word
    typedef enum logic [2:0] {
        OP_DEV_EQ_ROM,
        OP_DEV_EQ_RAM,
        OP_DEV_EQ_RAMZP,
        OP_DEV_EQ_UART,
        OP_NONREG_EQ_OPREGY,
        OP_REGX_EQ_ALU,
        OP_RAMZP_EQ_REG,
        OP_RAMZP_EQ_UART
    } op_sel_e;

    // alu function select, sub is x minus y
    typedef enum logic [2:0] {
        ALU_PASSX,
        ALU_PASSY,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOTX
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_EXEC,
        ST_BUS,
        ST_HALT
    } seq_state_e;

    // 24-bit program word, hi byte first
    typedef struct packed {
        op_sel_e op;
        dev_t dev;
        alu_op_e alu_op;
        reg_sel_t x_sel;
        reg_sel_t y_sel;
        logic spare;
        data_t imm;
    } instr_t;

    // decoded strobes from the control selector
    typedef struct packed {
        logic rom_out;
        logic ram_out;
        logic alu_out;
        logic uart_out;
        logic ram_zp;
        logic force_alu_op_to_passx;
        logic force_x_val_to_zero;
        dev_t device_in;
    } ctrl_t;

    // wishbone classic master outputs
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        addr_t adr;
        data_t dat;
    } wb_req_t;

endpackage

// File: src/control_selector.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module control_selector (
    input  cpu_pkg::data_t hi,
    output cpu_pkg::ctrl_t ctrl
);
    import cpu_pkg::*;

    op_sel_e op;
    logic [7:0] op_hot;
    logic zp_write_op;
    logic reg_bit;

    // operation lives in the top three bits of the hi byte
    assign op = op_sel_e'(hi[7:5]);

    always_comb begin
        // one-hot decode, one line per operation
        op_hot = 8'b1 << op;

        // immediate drives the source byte only for the rom op
        ctrl.rom_out = op_hot[OP_DEV_EQ_ROM];

        // both ram reads share one select, address picked by ram_zp
        ctrl.ram_out = op_hot[OP_DEV_EQ_RAM] | op_hot[OP_DEV_EQ_RAMZP];

        // uart reads, to a device or on the way to zero page
        ctrl.uart_out = op_hot[OP_DEV_EQ_UART] | op_hot[OP_RAMZP_EQ_UART];

        // alu is the source for the three register ops
        ctrl.alu_out = op_hot[OP_NONREG_EQ_OPREGY]
                     | op_hot[OP_REGX_EQ_ALU]
                     | op_hot[OP_RAMZP_EQ_REG];

        // zero page: high address byte held at zero, low byte from the immediate
        ctrl.ram_zp = op_hot[OP_DEV_EQ_RAMZP]
                    | op_hot[OP_RAMZP_EQ_REG]
                    | op_hot[OP_RAMZP_EQ_UART];

        // storing a register to zero page routes x straight through the alu
        ctrl.force_alu_op_to_passx = op_hot[OP_RAMZP_EQ_REG];

        // the non-register op works on y alone, so x reads as zero
        ctrl.force_x_val_to_zero = op_hot[OP_NONREG_EQ_OPREGY];

        // these two ops write to zero page over the bus
        zp_write_op = op_hot[OP_RAMZP_EQ_REG] | op_hot[OP_RAMZP_EQ_UART];

        // top device bit selects the register file
        // low for the non-register op, always set for regx
        if (op_hot[OP_REGX_EQ_ALU]) begin
            reg_bit = 1'b1;
        end else if (op_hot[OP_NONREG_EQ_OPREGY]) begin
            reg_bit = 1'b0;
        end else begin
            reg_bit = hi[`DEV_W-1];
        end

        // a zero-page write has the bus as its only destination
        if (zp_write_op) begin
            ctrl.device_in = `DEV_NONE;
        end else begin
            ctrl.device_in = {reg_bit, hi[`DEV_W-2:0]};
        end
    end

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::data_t x_val,
    input  cpu_pkg::data_t y_val,
    input  cpu_pkg::alu_op_e alu_op,
    input  logic force_alu_op_to_passx,
    input  logic force_x_val_to_zero,
    output cpu_pkg::data_t result
);
    import cpu_pkg::*;

    data_t x_eff;
    alu_op_e op_eff;

    // overrides from the control selector
    assign x_eff = force_x_val_to_zero ? '0 : x_val;
    assign op_eff = force_alu_op_to_passx ? ALU_PASSX : alu_op;

    always_comb begin
        case (op_eff)
            ALU_PASSX: begin
                result = x_eff;
            end
            ALU_PASSY: begin
                result = y_val;
            end
            // add and sub wrap at 8 bits, no carry out
            ALU_ADD: begin
                result = x_eff + y_val;
            end
            ALU_SUB: begin
                result = x_eff - y_val;
            end
            ALU_AND: begin
                result = x_eff & y_val;
            end
            ALU_OR: begin
                result = x_eff | y_val;
            end
            ALU_XOR: begin
                result = x_eff ^ y_val;
            end
            ALU_NOTX: begin
                result = ~x_eff;
            end
            default: begin
                result = x_eff;
            end
        endcase
    end

endmodule

// File: src/register_bank.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_bank (
    input  logic clk,
    input  logic reset,
    input  logic wr_en,
    input  cpu_pkg::dev_t wr_dev,
    input  cpu_pkg::data_t wr_data,
    input  cpu_pkg::reg_sel_t x_sel,
    input  cpu_pkg::reg_sel_t y_sel,
    output cpu_pkg::data_t x_val,
    output cpu_pkg::data_t y_val,
    output cpu_pkg::addr_t mar
);
    import cpu_pkg::*;

    data_t regs [4];
    data_t mar_lo;
    data_t mar_hi;
    logic reg_hit;
    reg_sel_t reg_idx;

    // registers occupy four consecutive codes from DEV_REG0
    assign reg_hit = (wr_dev & ~`DEV_W'(3)) == `DEV_REG0;
    assign reg_idx = wr_dev[1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
            mar_lo <= '0;
            mar_hi <= '0;
        end else if (wr_en) begin
            // other device codes belong to the sequencer or the bus
            if (reg_hit) begin
                regs[reg_idx] <= wr_data;
            end else if (wr_dev == `DEV_MARLO) begin
                mar_lo <= wr_data;
            end else if (wr_dev == `DEV_MARHI) begin
                mar_hi <= wr_data;
            end
        end
    end

    // operand reads are combinational
    assign x_val = regs[x_sel];
    assign y_val = regs[y_sel];

    // two-byte memory address
    assign mar = {mar_hi, mar_lo};

endmodule

// File: src/bus_sequencer.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module bus_sequencer (
    input  logic clk,
    input  logic reset,
    input  cpu_pkg::instr_t instr,
    input  cpu_pkg::ctrl_t ctrl,
    input  cpu_pkg::data_t alu_result,
    input  cpu_pkg::addr_t mar,
    input  cpu_pkg::data_t wb_dat_r,
    input  logic wb_ack,
    output cpu_pkg::pc_t pc,
    output cpu_pkg::wb_req_t wb_req,
    output logic wr_en,
    output cpu_pkg::dev_t wr_dev,
    output cpu_pkg::data_t wr_data,
    output logic halted
);
    import cpu_pkg::*;

    seq_state_e state;
    logic wr_pend;
    data_t rd_data;
    logic zp_write;
    logic bus_read;
    logic bus_write;
    logic read_ack;
    logic finish;
    addr_t zp_addr;
    addr_t rd_addr;
    addr_t wr_addr;
    data_t bus_byte;
    data_t src_byte;

    assign zp_addr = {{(`ADDR_W - `DATA_W){1'b0}}, instr.imm};

    always_comb begin
        // zero-page ops without a ram read are writes to zero page
        zp_write = ctrl.ram_zp & ~ctrl.ram_out;
        bus_read = ctrl.ram_out | ctrl.uart_out;
        bus_write = zp_write
                  | (ctrl.device_in == `DEV_RAM)
                  | (ctrl.device_in == `DEV_UART);

        // read side: uart, zero page or mar
        if (ctrl.uart_out) begin
            rd_addr = `UART_ADDR;
        end else if (ctrl.ram_zp) begin
            rd_addr = zp_addr;
        end else begin
            rd_addr = mar;
        end

        // write side
        if (zp_write) begin
            wr_addr = zp_addr;
        end else if (ctrl.device_in == `DEV_UART) begin
            wr_addr = `UART_ADDR;
        end else begin
            wr_addr = mar;
        end

        // live bus data on the acking edge of a read, captured copy after it
        read_ack = (state == ST_BUS) & wb_req.cyc & ~wb_req.we & wb_ack;
        bus_byte = read_ack ? wb_dat_r : rd_data;

        if (ctrl.rom_out) begin
            src_byte = instr.imm;
        end else if (ctrl.alu_out) begin
            src_byte = alu_result;
        end else begin
            src_byte = bus_byte;
        end

        // last cycle of the instruction
        case (state)
            ST_EXEC: finish = ~bus_read & ~bus_write;
            ST_BUS:  finish = wb_req.cyc & wb_ack & ~wr_pend;
            default: finish = 1'b0;
        endcase
    end

    // register bank picks out its own device codes
    assign wr_en = finish;
    assign wr_dev = ctrl.device_in;
    assign wr_data = src_byte;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_EXEC;
            pc <= '0;
            wb_req <= '0;
            wr_pend <= 1'b0;
            halted <= 1'b0;
        end else begin
            case (state)
                ST_EXEC: begin
                    // request goes out the cycle after decode, read first if any
                    if (bus_read | bus_write) begin
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        wb_req.we <= ~bus_read;
                        wb_req.adr <= bus_read ? rd_addr : wr_addr;
                        wb_req.dat <= src_byte;
                        wr_pend <= bus_read & bus_write;
                        state <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (!wb_req.cyc) begin
                        // idle cycle after the read, now write the captured byte
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        wb_req.we <= 1'b1;
                        wb_req.adr <= wr_addr;
                        wb_req.dat <= rd_data;
                        wr_pend <= 1'b0;
                    end else if (wb_ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        if (!wr_pend) begin
                            state <= ST_EXEC;
                        end
                    end
                end
                default: begin
                    // halted, only reset leaves here
                    state <= ST_HALT;
                end
            endcase

            // pc moves on the final edge of each instruction
            if (finish) begin
                if (ctrl.device_in == `DEV_HALT) begin
                    state <= ST_HALT;
                    halted <= 1'b1;
                end else if (ctrl.device_in == `DEV_PC) begin
                    pc <= src_byte;
                end else begin
                    pc <= pc + pc_t'(1);
                end
            end
        end
    end

    // read data capture
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_data <= '0;
        end else if (read_ack) begin
            rd_data <= wb_dat_r;
        end
    end

endmodule

// File: src/spam_cpu.sv
`timescale 1ns/1ps

module spam_cpu (
    input  logic clk,
    input  logic reset,
    input  cpu_pkg::instr_t instr,
    output cpu_pkg::pc_t pc,
    output cpu_pkg::wb_req_t wb_req,
    input  cpu_pkg::data_t wb_dat_r,
    input  logic wb_ack,
    output logic halted
);
    import cpu_pkg::*;

    ctrl_t ctrl;
    data_t x_val;
    data_t y_val;
    addr_t mar;
    data_t alu_result;
    logic wr_en;
    dev_t wr_dev;
    data_t wr_data;

    // decode looks only at the hi byte
    control_selector u_control_selector (
        .hi   ({instr.op, instr.dev}),
        .ctrl (ctrl)
    );

    alu u_alu (
        .x_val                 (x_val),
        .y_val                 (y_val),
        .alu_op                (instr.alu_op),
        .force_alu_op_to_passx (ctrl.force_alu_op_to_passx),
        .force_x_val_to_zero   (ctrl.force_x_val_to_zero),
        .result                (alu_result)
    );

    // operand selects come straight from the mid byte
    register_bank u_register_bank (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_dev  (wr_dev),
        .wr_data (wr_data),
        .x_sel   (instr.x_sel),
        .y_sel   (instr.y_sel),
        .x_val   (x_val),
        .y_val   (y_val),
        .mar     (mar)
    );

    bus_sequencer u_bus_sequencer (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .mar        (mar),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .pc         (pc),
        .wb_req     (wb_req),
        .wr_en      (wr_en),
        .wr_dev     (wr_dev),
        .wr_data    (wr_data),
        .halted     (halted)
    );

endmodule

// File: bench/tb_bus_model.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_bus_model (
    input  logic clk,
    input  logic reset,
    input  cpu_pkg::wb_req_t wb_req,
    input  cpu_pkg::data_t rx_byte,
    output cpu_pkg::data_t wb_dat_r,
    output logic wb_ack
);
    import cpu_pkg::*;

    // 256-byte ram, mirrored over the whole space apart from the uart
    data_t mem [256];
    int waits;

    initial begin
        wb_dat_r = '0;
        wb_ack = 1'b0;
        waits = -1;
        for (int i = 0; i < 256; i++) begin
            // fill depends on every address bit
            mem[i] = data_t'(i * 37 + 11);
        end
    end

    always begin
        @(posedge clk);
        #1;
        if (reset) begin
            wb_ack = 1'b0;
            waits = -1;
        end else if (wb_ack) begin
            // master saw ack on this edge and dropped cyc
            wb_ack = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            // pick 0 to 3 wait states per transfer
            if (waits < 0) begin
                waits = int'($urandom % 4);
            end
            if (waits == 0) begin
                wb_ack = 1'b1;
                waits = -1;
                if (wb_req.we) begin
                    // uart writes are checked in the testbench top
                    if (wb_req.adr != `UART_ADDR) begin
                        mem[wb_req.adr[7:0]] = wb_req.dat;
                    end
                end else if (wb_req.adr == `UART_ADDR) begin
                    wb_dat_r = rx_byte;
                end else begin
                    wb_dat_r = mem[wb_req.adr[7:0]];
                end
            end else begin
                waits = waits - 1;
            end
        end
    end

endmodule

// File: bench/tb_spam_cpu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_spam_cpu;
    import cpu_pkg::*;

    logic clk;
    logic reset;
    instr_t instr;
    pc_t pc;
    wb_req_t wb_req;
    data_t wb_dat_r;
    logic wb_ack;
    logic halted;
    data_t rx_byte;

    instr_t prog [256];
    int prog_len;
    data_t expected [$];

    spam_cpu DUT (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .pc       (pc),
        .wb_req   (wb_req),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .halted   (halted)
    );

    tb_bus_model u_bus_model (
        .clk      (clk),
        .reset    (reset),
        .wb_req   (wb_req),
        .rx_byte  (rx_byte),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    // expected alu result from the function table
    function automatic data_t alu_model(input alu_op_e op, input data_t x, input data_t y);
        case (op)
            ALU_PASSX: return x;
            ALU_PASSY: return y;
            ALU_ADD:   return data_t'(x + y);
            ALU_SUB:   return data_t'(x - y);
            ALU_AND:   return x & y;
            ALU_OR:    return x | y;
            ALU_XOR:   return x ^ y;
            default:   return ~x;
        endcase
    endfunction

    // request held steady while the slave stalls
    assert property (@(posedge clk) disable iff (reset)
        (wb_req.cyc && !wb_ack) |=> $stable(wb_req))
        else fail_run("wishbone request changed while waiting for ack");
    assert property (@(posedge clk) disable iff (reset) wb_req.cyc == wb_req.stb)
        else fail_run("cyc and stb differ");
    assert property (@(posedge clk) disable iff (reset) halted |-> !wb_req.cyc)
        else fail_run("bus request outstanding after halt");

    // every uart write must match the next expected byte
    always @(posedge clk) begin
        if (!reset && wb_req.cyc && wb_req.we && wb_ack && wb_req.adr == `UART_ADDR) begin
            if (expected.size() == 0) begin
                fail_run("uart write with no byte expected");
            end else begin
                assert (wb_req.dat == expected[0]) else begin
                    $display("error wb_req.dat got %h expected %h", wb_req.dat, expected[0]);
                    fail_run("uart byte mismatch");
                end
                void'(expected.pop_front());
            end
        end
    end

    // combinational fetch port, updated after pc settles
    always begin
        @(posedge clk);
        #1;
        instr = prog[pc];
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_word(input op_sel_e op, input dev_t dev, input alu_op_e a,
                            input reg_sel_t x, input reg_sel_t y, input data_t imm);
        prog[prog_len] = '{op: op, dev: dev, alu_op: a, x_sel: x, y_sel: y,
                           spare: 1'b0, imm: imm};
        prog_len++;
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            prog[i] = '{op: OP_DEV_EQ_ROM, dev: `DEV_HALT, alu_op: ALU_PASSX,
                        x_sel: 2'd0, y_sel: 2'd0, spare: 1'b0, imm: 8'h00};
        end
        prog_len = 0;
    endtask

    // echo register y to the uart through the non-register op
    task automatic echo_reg(input reg_sel_t r, input data_t value);
        add_word(OP_NONREG_EQ_OPREGY, `DEV_UART, ALU_PASSY, 2'd0, r, 8'h00);
        expected.push_back(value);
    endtask

    // pc at zero, no bus cycle and not halted
    task automatic check_cleared();
        assert (pc == 8'h00) else begin
            $display("error pc got %h expected %h", pc, 8'h00);
            fail_run("pc not cleared by reset");
        end
        assert (!wb_req.cyc) else begin
            $display("error wb_req.cyc got %h expected %h", wb_req.cyc, 1'b0);
            fail_run("bus cycle active around reset");
        end
        assert (!halted) else begin
            $display("error halted got %h expected %h", halted, 1'b0);
            fail_run("halted set around reset");
        end
    endtask

    // still halted and the bus idle
    task automatic check_quiet_halt();
        assert (halted) else begin
            $display("error halted got %h expected %h", halted, 1'b1);
            fail_run("core left the halt state");
        end
        assert (!wb_req.cyc) else begin
            $display("error wb_req.cyc got %h expected %h", wb_req.cyc, 1'b0);
            fail_run("bus activity after halt");
        end
    endtask

    task automatic run_program();
        int n;
        add_word(OP_DEV_EQ_ROM, `DEV_HALT, ALU_PASSX, 2'd0, 2'd0, 8'h00);
        @(posedge clk);
        #1;
        reset = 1'b1;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            check_cleared();
        end
        reset = 1'b0;
        check_cleared();
        n = 0;
        while (!halted) begin
            if (n > 2000) begin
                fail_run("timeout waiting for halt");
            end
            @(posedge clk);
            #1;
            n++;
        end
        // stays halted with a quiet bus
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            #1;
            check_quiet_halt();
        end
        assert (expected.size() == 0) else fail_run("uart bytes missing at halt");
    endtask

    initial begin
        data_t a;
        data_t b;
        data_t c;
        data_t zp;
        reset = 1'b1;
        rx_byte = 8'h00;
        instr = '0;
        void'($urandom(31637));
        clear_program();

        // immediates straight to the uart, then echoed through registers
        for (int i = 0; i < 4; i++) begin
            a = data_t'($urandom);
            add_word(OP_DEV_EQ_ROM, `DEV_UART, ALU_PASSX, 2'd0, 2'd0, a);
            expected.push_back(a);
            add_word(OP_DEV_EQ_ROM, dev_t'(`DEV_REG0 + i), ALU_PASSX, 2'd0, 2'd0, a);
            echo_reg(reg_sel_t'(i), a);
        end
        run_program();

        // every alu function, register form and x-zero form
        clear_program();
        a = data_t'($urandom);
        b = data_t'($urandom);
        add_word(OP_DEV_EQ_ROM, `DEV_REG0, ALU_PASSX, 2'd0, 2'd0, a);
        add_word(OP_DEV_EQ_ROM, dev_t'(`DEV_REG0 + 1), ALU_PASSX, 2'd0, 2'd0, b);
        for (int k = 0; k < 8; k++) begin
            add_word(OP_REGX_EQ_ALU, dev_t'(`DEV_REG0 + 2), alu_op_e'(k), 2'd0, 2'd1, 8'h00);
            echo_reg(2'd2, alu_model(alu_op_e'(k), a, b));
            add_word(OP_NONREG_EQ_OPREGY, `DEV_UART, alu_op_e'(k), 2'd0, 2'd1, 8'h00);
            expected.push_back(alu_model(alu_op_e'(k), 8'h00, b));
        end
        run_program();

        // zero page and mar round trips
        clear_program();
        a = data_t'($urandom);
        c = data_t'($urandom);
        zp = data_t'($urandom);
        add_word(OP_DEV_EQ_ROM, `DEV_REG0, ALU_PASSX, 2'd0, 2'd0, a);
        add_word(OP_RAMZP_EQ_REG, `DEV_NONE, ALU_XOR, 2'd0, 2'd1, zp);
        add_word(OP_DEV_EQ_RAMZP, dev_t'(`DEV_REG0 + 1), ALU_PASSX, 2'd0, 2'd0, zp);
        echo_reg(2'd1, a);
        add_word(OP_DEV_EQ_ROM, `DEV_MARLO, ALU_PASSX, 2'd0, 2'd0, data_t'($urandom));
        add_word(OP_DEV_EQ_ROM, `DEV_MARHI, ALU_PASSX, 2'd0, 2'd0, 8'h12);
        add_word(OP_DEV_EQ_ROM, `DEV_RAM, ALU_PASSX, 2'd0, 2'd0, c);
        add_word(OP_DEV_EQ_RAM, dev_t'(`DEV_REG0 + 2), ALU_PASSX, 2'd0, 2'd0, 8'h00);
        echo_reg(2'd2, c);
        run_program();

        // uart receive into a register and into zero page
        clear_program();
        rx_byte = data_t'($urandom);
        zp = data_t'($urandom);
        add_word(OP_DEV_EQ_UART, `DEV_REG0, ALU_PASSX, 2'd0, 2'd0, 8'h00);
        echo_reg(2'd0, rx_byte);
        add_word(OP_RAMZP_EQ_UART, `DEV_NONE, ALU_PASSX, 2'd0, 2'd0, zp);
        add_word(OP_DEV_EQ_RAMZP, `DEV_UART, ALU_PASSX, 2'd0, 2'd0, zp);
        expected.push_back(rx_byte);
        run_program();

        // jump over two poison writes
        clear_program();
        add_word(OP_DEV_EQ_ROM, `DEV_PC, ALU_PASSX, 2'd0, 2'd0, 8'h03);
        add_word(OP_DEV_EQ_ROM, `DEV_UART, ALU_PASSX, 2'd0, 2'd0, 8'hEE);
        add_word(OP_DEV_EQ_ROM, `DEV_UART, ALU_PASSX, 2'd0, 2'd0, 8'hEE);
        add_word(OP_DEV_EQ_ROM, `DEV_UART, ALU_PASSX, 2'd0, 2'd0, 8'h5A);
        expected.push_back(8'h5A);
        run_program();

        $display("all tests passed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+src
src/cpu_pkg.sv
src/control_selector.sv
src/alu.sv
src/register_bank.sv
src/bus_sequencer.sv
src/spam_cpu.sv
bench/tb_bus_model.sv
bench/tb_spam_cpu.sv

// File: run.sh
#!/bin/sh
# build and run the testbench, exit status reflects pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_spam_cpu -o sim_tb &&
./obj_dir/sim_tb || exit 1
